// ==== include/gfx_cfg.svh ====
`ifndef GFX_CFG_SVH
`define GFX_CFG_SVH

// Horizontal raster in pixel clocks
`define GFX_H_ACTIVE 640
`define GFX_H_FRONT 16
`define GFX_H_SYNC 96
// Active, front porch, sync and back porch together
`define GFX_H_TOTAL 800

// Vertical raster in lines
`define GFX_V_ACTIVE 480
`define GFX_V_FRONT 10
`define GFX_V_SYNC 2
`define GFX_V_TOTAL 525

// Sprite layer
`define GFX_NUM_SPRITES 4

// Side of the square sprite, in pixels
`define GFX_SPRITE_SIZE 16

`endif

// ==== verilog/gfx_pkg.sv ====
`default_nettype none

package gfx_pkg;

	// Raster or pixel coordinate
	typedef logic [9:0] coord_t;

	// RGB444, red in the top nibble
	typedef logic [11:0] color_t;

	// Palette index, 0 is transparent
	typedef logic [7:0] color_index_t;

	// CPU port
	typedef logic [11:0] cpu_addr_t;
	typedef logic [15:0] cpu_data_t;

	// Beam position, already scaled for the video mode
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic visible;
	} beam_t;

	// Field codes: 0 x, 1 y, 2 color index, 3 enable
	typedef struct packed {
		logic valid;
		logic [1:0] num;
		logic [1:0] field;
		cpu_data_t data;
	} sprite_wr_t;

	typedef struct packed {
		logic valid;
		color_index_t index;
		color_t data;
	} pal_wr_t;

endpackage

`default_nettype wire

// ==== verilog/video_timing.sv ====
`default_nettype none
`include "gfx_cfg.svh"

module video_timing
(
	input wire CLK,
	input wire RSTb,
	input wire video_mode,
	output gfx_pkg::beam_t beam,
	output gfx_pkg::coord_t line,
	output logic [5:0] frame_count,
	output logic hs,
	output logic vs,
	output logic irq_hsync,
	output logic irq_vsync
);

	localparam gfx_pkg::coord_t H_ACTIVE = gfx_pkg::coord_t'(`GFX_H_ACTIVE);
	localparam gfx_pkg::coord_t H_LAST = gfx_pkg::coord_t'(`GFX_H_TOTAL - 1);
	localparam gfx_pkg::coord_t HS_START = gfx_pkg::coord_t'(`GFX_H_ACTIVE + `GFX_H_FRONT);
	localparam gfx_pkg::coord_t HS_STOP = gfx_pkg::coord_t'(HS_START + `GFX_H_SYNC);

	localparam gfx_pkg::coord_t V_ACTIVE = gfx_pkg::coord_t'(`GFX_V_ACTIVE);
	localparam gfx_pkg::coord_t V_LAST = gfx_pkg::coord_t'(`GFX_V_TOTAL - 1);
	localparam gfx_pkg::coord_t VS_START = gfx_pkg::coord_t'(`GFX_V_ACTIVE + `GFX_V_FRONT);
	localparam gfx_pkg::coord_t VS_STOP = gfx_pkg::coord_t'(VS_START + `GFX_V_SYNC);

	gfx_pkg::coord_t hcount;
	gfx_pkg::coord_t vcount;
	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (hcount == H_LAST);
	assign v_wrap = (vcount == V_LAST);

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			hcount <= '0;
			vcount <= '0;
			frame_count <= '0;
		end
		else
		begin
			hcount <= h_wrap ? '0 : hcount + 1'b1;
			if (h_wrap)
			begin
				vcount <= v_wrap ? '0 : vcount + 1'b1;
				// Counters return to 0,0 here
				if (v_wrap)
					frame_count <= frame_count + 1'b1;
			end
		end
	end

	// Sync pulses are active low
	assign hs = !((hcount >= HS_START) && (hcount < HS_STOP));
	assign vs = !((vcount >= VS_START) && (vcount < VS_STOP));
	assign irq_hsync = (hcount == HS_START);
	assign irq_vsync = (vcount == VS_START) && (hcount == '0);

	assign line = vcount;

	// Pixel doubling halves both coordinates, visibility stays on the raw raster
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			beam <= '0;
		else
		begin
			beam.x <= video_mode ? (hcount >> 1) : hcount;
			beam.y <= video_mode ? (vcount >> 1) : vcount;
			beam.visible <= (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/reg_decode.sv ====
`default_nettype none
`include "gfx_cfg.svh"

module reg_decode
(
	input wire CLK,
	input wire RSTb,
	input wire gfx_pkg::cpu_addr_t addr,
	input wire gfx_pkg::cpu_data_t wdata,
	input wire wr,
	output gfx_pkg::cpu_data_t rdata,
	input wire gfx_pkg::coord_t line,
	input wire [5:0] frame_count,
	output logic video_mode,
	output gfx_pkg::color_t bg_color,
	output gfx_pkg::sprite_wr_t sprite_wr,
	output gfx_pkg::pal_wr_t pal_wr
);

	localparam gfx_pkg::cpu_addr_t ADDR_FRAME = 12'hf00;
	localparam gfx_pkg::cpu_addr_t ADDR_LINE = 12'hf01;
	localparam gfx_pkg::cpu_addr_t ADDR_MODE = 12'hf02;
	localparam gfx_pkg::cpu_addr_t ADDR_BG = 12'hf03;

	gfx_pkg::cpu_addr_t addr_q;
	logic sprite_sel;
	logic pal_sel;

	// Sprite s lives at 0x0s0..0x0s3
	assign sprite_sel = (addr[11:8] == 4'h0) && (addr[7:4] < `GFX_NUM_SPRITES)
		&& (addr[3:2] == 2'b00);

	// Palette entry xx at 0xexx
	assign pal_sel = (addr[11:8] == 4'he);

	always_comb
	begin
		sprite_wr.valid = wr && sprite_sel;
		sprite_wr.num = addr[5:4];
		sprite_wr.field = addr[1:0];
		sprite_wr.data = wdata;
	end

	always_comb
	begin
		pal_wr.valid = wr && pal_sel;
		pal_wr.index = addr[7:0];
		pal_wr.data = wdata[11:0];
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			addr_q <= '0;
			video_mode <= 1'b0;
			bg_color <= '0;
		end
		else
		begin
			addr_q <= addr;
			if (wr && (addr == ADDR_MODE))
				video_mode <= wdata[0];
			if (wr && (addr == ADDR_BG))
				bg_color <= wdata[11:0];
		end
	end

	// Read back from last cycle's address, unmapped reads as zero
	always_comb
	begin
		rdata = '0;
		case (addr_q)
			ADDR_FRAME:
				rdata[5:0] = frame_count;
			ADDR_LINE:
				rdata[9:0] = video_mode ? (line >> 1) : line;
			ADDR_MODE:
				rdata[0] = video_mode;
			ADDR_BG:
				rdata[11:0] = bg_color;
			default:
				rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/sprite_engine.sv ====
`default_nettype none
`include "gfx_cfg.svh"

module sprite_engine
(
	input wire CLK,
	input wire RSTb,
	input wire gfx_pkg::sprite_wr_t sprite_wr,
	input wire gfx_pkg::beam_t beam,
	output gfx_pkg::color_index_t index
);

	localparam int NUM = `GFX_NUM_SPRITES;
	localparam gfx_pkg::coord_t SIZE = gfx_pkg::coord_t'(`GFX_SPRITE_SIZE);

	gfx_pkg::coord_t sp_x [NUM];
	gfx_pkg::coord_t sp_y [NUM];
	gfx_pkg::color_index_t sp_index [NUM];
	logic [NUM-1:0] sp_en;
	gfx_pkg::color_index_t hit_index;

	// Pos falls in [start, start + SIZE), the offset avoids overflow near the edge
	function automatic logic in_span(gfx_pkg::coord_t pos, gfx_pkg::coord_t start);
		gfx_pkg::coord_t offset;
		offset = pos - start;
		return (pos >= start) && (offset < SIZE);
	endfunction

	// Position and color fields
	always_ff @(posedge CLK)
	begin
		if (sprite_wr.valid)
		begin
			case (sprite_wr.field)
				2'd0:
					sp_x[sprite_wr.num] <= sprite_wr.data[9:0];
				2'd1:
					sp_y[sprite_wr.num] <= sprite_wr.data[9:0];
				2'd2:
					sp_index[sprite_wr.num] <= sprite_wr.data[7:0];
				default:
					;
			endcase
		end
	end

	// Enables come up cleared
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			sp_en <= '0;
		else if (sprite_wr.valid && (sprite_wr.field == 2'd3))
			sp_en[sprite_wr.num] <= sprite_wr.data[0];
	end

	always_comb
	begin
		hit_index = '0;
		// Scan downward so the lowest-numbered hit is written last
		for (int i = NUM - 1; i >= 0; i--)
		begin
			if (sp_en[i] && in_span(beam.x, sp_x[i]) && in_span(beam.y, sp_y[i]))
				hit_index = sp_index[i];
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			index <= '0;
		else
			index <= hit_index;
	end

endmodule

`default_nettype wire

// ==== verilog/palette_output.sv ====
`default_nettype none

module palette_output
(
	input wire CLK,
	input wire RSTb,
	input wire gfx_pkg::pal_wr_t pal_wr,
	input wire gfx_pkg::color_t bg_color,
	input wire gfx_pkg::color_index_t index,
	input wire gfx_pkg::beam_t beam,
	output logic [3:0] rr,
	output logic [3:0] gg,
	output logic [3:0] bb
);

	gfx_pkg::color_t pal_ram [256];
	logic visible_q;
	gfx_pkg::color_t pixel_q;

	always_ff @(posedge CLK)
	begin
		if (pal_wr.valid)
			pal_ram[pal_wr.index] <= pal_wr.data;
	end

	// Visible bit delayed to line up with the sprite index
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			visible_q <= 1'b0;
		else
			visible_q <= beam.visible;
	end

	// Synchronous palette read, background choice and blanking in one stage
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
			pixel_q <= '0;
		else if (!visible_q)
			pixel_q <= '0;
		else if (index == '0)
			pixel_q <= bg_color;
		else
			pixel_q <= pal_ram[index];
	end

	assign rr = pixel_q[11:8];
	assign gg = pixel_q[7:4];
	assign bb = pixel_q[3:0];

endmodule

`default_nettype wire

// ==== verilog/gfx_top.sv ====
`default_nettype none

module gfx_top
(
	input wire CLK,
	input wire RSTb,
	input wire gfx_pkg::cpu_addr_t addr,
	input wire gfx_pkg::cpu_data_t wdata,
	input wire wr,
	output gfx_pkg::cpu_data_t rdata,
	output logic hs,
	output logic vs,
	output logic [3:0] rr,
	output logic [3:0] gg,
	output logic [3:0] bb,
	output logic irq_hsync,
	output logic irq_vsync
);

	gfx_pkg::beam_t beam;
	gfx_pkg::coord_t line;
	logic [5:0] frame_count;
	logic video_mode;
	gfx_pkg::color_t bg_color;
	gfx_pkg::sprite_wr_t sprite_wr;
	gfx_pkg::pal_wr_t pal_wr;
	gfx_pkg::color_index_t index;

	video_timing u_timing
	(
		.CLK(CLK),
		.RSTb(RSTb),
		.video_mode(video_mode),
		.beam(beam),
		.line(line),
		.frame_count(frame_count),
		.hs(hs),
		.vs(vs),
		.irq_hsync(irq_hsync),
		.irq_vsync(irq_vsync)
	);

	reg_decode u_decode
	(
		.CLK(CLK),
		.RSTb(RSTb),
		.addr(addr),
		.wdata(wdata),
		.wr(wr),
		.rdata(rdata),
		.line(line),
		.frame_count(frame_count),
		.video_mode(video_mode),
		.bg_color(bg_color),
		.sprite_wr(sprite_wr),
		.pal_wr(pal_wr)
	);

	sprite_engine u_sprites
	(
		.CLK(CLK),
		.RSTb(RSTb),
		.sprite_wr(sprite_wr),
		.beam(beam),
		.index(index)
	);

	palette_output u_palette
	(
		.CLK(CLK),
		.RSTb(RSTb),
		.pal_wr(pal_wr),
		.bg_color(bg_color),
		.index(index),
		.beam(beam),
		.rr(rr),
		.gg(gg),
		.bb(bb)
	);

endmodule

`default_nettype wire

// ==== verif/gfx_tb.sv ====
`default_nettype none
`include "gfx_cfg.svh"

module gfx_tb;

	localparam int H_TOTAL = `GFX_H_TOTAL;
	localparam int V_TOTAL = `GFX_V_TOTAL;
	localparam int FRAME_CYCLES = `GFX_H_TOTAL * `GFX_V_TOTAL;
	localparam int HS_START = `GFX_H_ACTIVE + `GFX_H_FRONT;
	localparam int HS_END = HS_START + `GFX_H_SYNC;
	localparam int VS_START = `GFX_V_ACTIVE + `GFX_V_FRONT;
	localparam int VS_END = VS_START + `GFX_V_SYNC;
	localparam int SIZE = `GFX_SPRITE_SIZE;

	logic CLK;
	logic RSTb;
	gfx_pkg::cpu_addr_t addr;
	gfx_pkg::cpu_data_t wdata;
	logic wr;
	gfx_pkg::cpu_data_t rdata;
	logic hs;
	logic vs;
	logic [3:0] rr;
	logic [3:0] gg;
	logic [3:0] bb;
	logic irq_hsync;
	logic irq_vsync;

	// Reference model state
	int mh;
	int mv;
	int frames;
	logic mode;
	gfx_pkg::color_t bg;
	gfx_pkg::color_t pal [256];
	int sx [4];
	int sy [4];
	logic [7:0] sidx [4];
	logic [3:0] sen;
	gfx_pkg::color_t pix_q [$];

	gfx_top uut
	(
		.CLK(CLK),
		.RSTb(RSTb),
		.addr(addr),
		.wdata(wdata),
		.wr(wr),
		.rdata(rdata),
		.hs(hs),
		.vs(vs),
		.rr(rr),
		.gg(gg),
		.bb(bb),
		.irq_hsync(irq_hsync),
		.irq_vsync(irq_vsync)
	);

	always #5 CLK = ~CLK;

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Fail at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	// Color the model expects for one raster position
	function automatic gfx_pkg::color_t model_pixel(input int h, input int v);
		int x;
		int y;
		int i;
		logic found;
		gfx_pkg::color_t c;
		if (h >= `GFX_H_ACTIVE || v >= `GFX_V_ACTIVE)
			return '0;
		x = mode ? h / 2 : h;
		y = mode ? v / 2 : v;
		c = bg;
		found = 1'b0;
		for (i = 0; i < 4; i++)
		begin
			if (!found && sen[i] && x >= sx[i] && x < sx[i] + SIZE
				&& y >= sy[i] && y < sy[i] + SIZE)
			begin
				found = 1'b1;
				if (sidx[i] != 8'd0)
					c = pal[sidx[i]];
			end
		end
		return c;
	endfunction

	// Register map as seen by the CPU
	function automatic void apply_write(input gfx_pkg::cpu_addr_t a,
		input gfx_pkg::cpu_data_t d);
		if (a[11:4] < 8'd4 && a[3:0] < 4'd4)
		begin
			case (a[1:0])
				2'd0: sx[a[5:4]] = d[9:0];
				2'd1: sy[a[5:4]] = d[9:0];
				2'd2: sidx[a[5:4]] = d[7:0];
				default: sen[a[5:4]] = d[0];
			endcase
		end
		else if (a[11:8] == 4'he)
			pal[a[7:0]] = d[11:0];
		else if (a == 12'hf02)
			mode = d[0];
		else if (a == 12'hf03)
			bg = d[11:0];
	endfunction

	// Advance the model one clock and check every output
	task automatic step();
		gfx_pkg::color_t exp_pix;
		@(posedge CLK);
		#1;
		if (mh == H_TOTAL - 1)
		begin
			mh = 0;
			if (mv == V_TOTAL - 1)
			begin
				mv = 0;
				frames = frames + 1;
			end
			else
				mv = mv + 1;
		end
		else
			mh = mh + 1;
		compare(hs, !(mh >= HS_START && mh < HS_END), "hs");
		compare(vs, !(mv >= VS_START && mv < VS_END), "vs");
		compare(irq_hsync, mh == HS_START, "irq_hsync");
		compare(irq_vsync, mv == VS_START && mh == 0, "irq_vsync");
		// Output shows the position from three clocks back
		pix_q.push_back(model_pixel(mh, mv));
		exp_pix = pix_q.pop_front();
		compare({rr, gg, bb}, exp_pix, "pixel");
	endtask

	task automatic write_reg(input gfx_pkg::cpu_addr_t a, input gfx_pkg::cpu_data_t d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		apply_write(a, d);
		step();
		wr = 1'b0;
	endtask

	task automatic read_check(input gfx_pkg::cpu_addr_t a, input string what);
		logic [31:0] expected;
		addr = a;
		step();
		case (a)
			12'hf00: expected = frames % 64;
			12'hf01: expected = mode ? mv / 2 : mv;
			12'hf02: expected = mode;
			12'hf03: expected = bg;
			default: expected = 0;
		endcase
		compare(rdata, expected, what);
	endtask

	task automatic wait_vsync();
		int n;
		step();
		n = 0;
		while (!irq_vsync && n < FRAME_CYCLES + 8)
		begin
			step();
			n++;
		end
		if (!irq_vsync)
		begin
			$display("STATUS: FAIL");
			$fatal(1, "Timed out waiting for the vertical sync interrupt");
		end
	endtask

	task automatic load_palette();
		int i;
		for (i = 0; i < 256; i++)
			write_reg(gfx_pkg::cpu_addr_t'(12'he00 + i), gfx_pkg::cpu_data_t'($urandom));
	endtask

	// Four overlapping sprites around a random corner with sprite 1 transparent
	task automatic place_sprites(input int x_max, input int y_max);
		int cx;
		int cy;
		int s;
		gfx_pkg::cpu_data_t idx;
		cx = $urandom % x_max;
		cy = $urandom % y_max;
		for (s = 0; s < 4; s++)
		begin
			idx = (s == 1) ? 16'd0 : gfx_pkg::cpu_data_t'(1 + $urandom % 255);
			write_reg(gfx_pkg::cpu_addr_t'(s * 16), gfx_pkg::cpu_data_t'(cx + $urandom % SIZE));
			write_reg(gfx_pkg::cpu_addr_t'(s * 16 + 1),
				gfx_pkg::cpu_data_t'(cy + $urandom % SIZE));
			write_reg(gfx_pkg::cpu_addr_t'(s * 16 + 2), idx);
			write_reg(gfx_pkg::cpu_addr_t'(s * 16 + 3), 16'd1);
		end
	endtask

	task automatic write_unmapped();
		gfx_pkg::cpu_addr_t a;
		case ($urandom % 3)
			0:
				a = {4'(1 + $urandom % 13), 8'($urandom)};
			1:
				a = gfx_pkg::cpu_addr_t'(12'hf04 + $urandom % 252);
			default:
			begin
				// Holes in the sprite page beyond field 3 or sprite 3
				if ($urandom % 2)
					a = {4'h0, 4'($urandom), 2'(1 + $urandom % 3), 2'($urandom)};
				else
					a = {4'h0, 4'(4 + $urandom % 12), 2'b00, 2'($urandom)};
			end
		endcase
		write_reg(a, gfx_pkg::cpu_data_t'($urandom));
	endtask

	initial
	begin
		CLK = 1'b0;
		RSTb = 1'b0;
		addr = '0;
		wdata = '0;
		wr = 1'b0;
		void'($urandom(32'h1a3ed2fb));
		mh = 0;
		mv = 0;
		frames = 0;
		mode = 1'b0;
		bg = '0;
		sen = '0;
		for (int i = 0; i < 256; i++)
			pal[i] = '0;
		repeat (8) @(posedge CLK);
		#1;
		compare(hs, 1'b1, "hs in reset");
		compare(vs, 1'b1, "vs in reset");
		compare(irq_hsync, 1'b0, "irq_hsync in reset");
		compare(irq_vsync, 1'b0, "irq_vsync in reset");
		compare({rr, gg, bb}, 12'h000, "rgb in reset");
		RSTb = 1'b1;
		// Two blank slots still in flight behind position 0,0
		pix_q.push_back(12'h000);
		pix_q.push_back(12'h000);
		pix_q.push_back(model_pixel(0, 0));

		// Two frames of sync and interrupts
		repeat (2 * FRAME_CYCLES) step();

		read_check(12'hf00, "frame count");
		read_check(12'hf01, "current line");
		read_check(12'hf02, "video mode");

		// Background only
		wait_vsync();
		load_palette();
		write_reg(12'hf03, gfx_pkg::cpu_data_t'($urandom));
		wait_vsync();
		read_check(12'hf03, "background color");

		// Overlapping sprites in mode 0
		load_palette();
		place_sprites(600, 440);
		wait_vsync();

		// Pixel doubled mode
		write_reg(12'hf02, 16'd1);
		place_sprites(300, 220);
		wait_vsync();
		read_check(12'hf02, "video mode after switch");
		read_check(12'hf01, "scaled line");
		read_check(12'hf00, "frame count later");

		// Unmapped writes leave the next frame untouched
		repeat (16) write_unmapped();
		wait_vsync();
		read_check(12'hf02, "video mode after unmapped writes");
		read_check(12'hf03, "background after unmapped writes");
		read_check(gfx_pkg::cpu_addr_t'(12'hf04 + $urandom % 252), "unmapped read");

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
verilog/gfx_pkg.sv
verilog/video_timing.sv
verilog/reg_decode.sv
verilog/sprite_engine.sv
verilog/palette_output.sv
verilog/gfx_top.sv
verif/gfx_tb.sv

// ==== Bender.yml ====
package:
  name: gfx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/gfx_pkg.sv
      - verilog/video_timing.sv
      - verilog/reg_decode.sv
      - verilog/sprite_engine.sv
      - verilog/palette_output.sv
      - verilog/gfx_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - verif/gfx_tb.sv
